// File: src/sld_pkg.sv
// slide unit shared definitions
// widths, encodings and the payload structs passed between pipeline stages

`default_nettype none

package sld_pkg;

    localparam int unsigned VREG_W = 128;         // vector register width in bits
    localparam int unsigned OP_W   = 32;          // chunk width in bits
    localparam int unsigned CHUNKS = VREG_W / OP_W;
    localparam int unsigned VREG_B = VREG_W / 8;  // bytes per register
    localparam int unsigned ID_W   = 3;

    typedef enum logic [1:0] {
        EEW_8  = 2'd0,
        EEW_16 = 2'd1,
        EEW_32 = 2'd2
    } eew_e;

    typedef enum logic {
        SLD_UP   = 1'b0,
        SLD_DOWN = 1'b1
    } dir_e;

    // operation as issued
    typedef struct packed {
        logic [ID_W-1:0] id;
        dir_e            dir;
        eew_e            eew;
        logic [3:0]      offset;  // in elements
        logic [4:0]      vl;      // 0 to 16 elements
        logic [4:0]      vs2;
        logic [4:0]      vd;
    } sld_op_t;

    // one chunk beat leaving the sequencer
    typedef struct packed {
        logic [ID_W-1:0] id;
        dir_e            dir;
        logic [1:0]      chunk;
        logic signed [5:0] boff;  // byte offset, negative for down slides
        logic [4:0]      vlb;     // vl in bytes, capped at VREG_B
        logic [4:0]      vd;
        logic            first;
        logic            last;
    } sld_beat_t;

    typedef struct packed {
        sld_beat_t       beat;
        logic [OP_W-1:0] hi;
        logic [OP_W-1:0] lo;
        logic            hi_vld;
        logic            lo_vld;
    } sld_opnd_t;

    typedef struct packed {
        sld_beat_t         beat;
        logic [OP_W-1:0]   data;
        logic [OP_W/8-1:0] mask;
    } sld_res_t;

    // register file write
    typedef struct packed {
        logic [4:0]        addr;
        logic [VREG_W-1:0] data;
        logic [VREG_B-1:0] mask;
        logic [ID_W-1:0]   id;
    } sld_wr_t;

endpackage

`default_nettype wire

// File: src/sld_pipe_reg.sv
// single valid/ready pipeline stage
// payload type is set per instance

`timescale 1ns/1ps
`default_nettype none

module sld_pipe_reg #(
    parameter type payload_t = logic
) (
    input  wire logic     clk_i,
    input  wire logic     async_rst_ni,
    input  wire logic     in_valid_i,
    input  wire payload_t in_i,
    output logic          in_ready_o,
    output logic          out_valid_o,
    output payload_t      out_o,
    input  wire logic     out_ready_i
);

    logic     valid_q;
    payload_t data_q;

    // accept when empty or when the held entry leaves this cycle
    assign in_ready_o = ~valid_q | out_ready_i;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            valid_q <= 1'b0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_ready_o && in_valid_i) begin
            data_q <= in_i;
        end
    end

    assign out_valid_o = valid_q;
    assign out_o       = data_q;

endmodule

`default_nettype wire

// File: src/sld_seq.sv
// slide sequencer
// accepts one operation at a time and issues one beat per destination chunk

`timescale 1ns/1ps
`default_nettype none

module sld_seq (
    input  wire logic               clk_i,
    input  wire logic               async_rst_ni,
    input  wire logic               op_valid_i,
    input  wire sld_pkg::sld_op_t   op_i,
    output logic                    op_ready_o,
    output logic [4:0]              vreg_rd_addr_o,
    output logic                    beat_valid_o,
    output sld_pkg::sld_beat_t      beat_o,
    input  wire logic               beat_ready_i
);

    sld_pkg::sld_op_t op_q;
    logic             busy_q;
    logic             rd_ok_q;  // read data for vs2 is available
    logic [1:0]       chunk_q;

    logic             accept;
    logic             beat_xfer;
    logic             last_beat;

    logic [1:0]       sz_sh;     // log2 of the element size in bytes
    logic [5:0]       boff_mag;
    logic [5:0]       boff_cap;
    logic [6:0]       vlb_raw;

    ////////////////////////////////////////////////////////////////////////////
    // handshakes

    assign beat_valid_o = busy_q & rd_ok_q;
    assign beat_xfer    = beat_valid_o & beat_ready_i;
    assign last_beat    = beat_xfer & (chunk_q == 2'(sld_pkg::CHUNKS - 1));
    assign op_ready_o   = ~busy_q | last_beat;  // next op may follow the last beat
    assign accept       = op_valid_i & op_ready_o;

    assign vreg_rd_addr_o = op_q.vs2;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            busy_q  <= 1'b0;
            rd_ok_q <= 1'b0;
            chunk_q <= 2'd0;
        end else if (accept) begin
            busy_q  <= 1'b1;
            rd_ok_q <= 1'b0;   // one cycle for the register read
            chunk_q <= 2'd0;
        end else if (last_beat) begin
            busy_q  <= 1'b0;
            rd_ok_q <= 1'b0;
        end else if (busy_q) begin
            rd_ok_q <= 1'b1;
            if (beat_xfer) begin
                chunk_q <= chunk_q + 2'd1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            op_q <= op_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // element to byte conversion

    always_comb begin
        case (op_q.eew)
            sld_pkg::EEW_16: sz_sh = 2'd1;
            sld_pkg::EEW_32: sz_sh = 2'd2;
            default:         sz_sh = 2'd0;
        endcase
    end

    assign boff_mag = {2'b00, op_q.offset} << sz_sh;
    assign boff_cap = (boff_mag > 6'(sld_pkg::VREG_B)) ? 6'(sld_pkg::VREG_B) : boff_mag;
    assign vlb_raw  = {2'b00, op_q.vl} << sz_sh;

    always_comb begin
        beat_o.id    = op_q.id;
        beat_o.dir   = op_q.dir;
        beat_o.chunk = chunk_q;
        beat_o.boff  = (op_q.dir == sld_pkg::SLD_DOWN) ? (6'd0 - boff_cap) : boff_cap;
        beat_o.vlb   = (vlb_raw > 7'(sld_pkg::VREG_B)) ? 5'(sld_pkg::VREG_B) : vlb_raw[4:0];
        beat_o.vd    = op_q.vd;
        beat_o.first = (chunk_q == 2'd0);
        beat_o.last  = (chunk_q == 2'(sld_pkg::CHUNKS - 1));
    end

endmodule

`default_nettype wire

// File: src/sld_operand.sv
// operand selection
// holds vs2 and picks the two source chunks feeding each destination chunk

`timescale 1ns/1ps
`default_nettype none

module sld_operand (
    input  wire logic                        clk_i,
    input  wire logic                        async_rst_ni,
    input  wire logic [sld_pkg::VREG_W-1:0]  vreg_rd_data_i,
    input  wire logic                        beat_valid_i,
    input  wire sld_pkg::sld_beat_t          beat_i,
    output logic                             beat_ready_o,
    output logic                             opnd_valid_o,
    output sld_pkg::sld_opnd_t               opnd_o,
    input  wire logic                        opnd_ready_i
);

    logic [sld_pkg::VREG_W-1:0] src_q;
    logic [sld_pkg::VREG_W-1:0] src;
    logic [4:0]                 hi_idx;  // signed chunk indices
    logic [4:0]                 lo_idx;

    assign beat_ready_o = opnd_ready_i;
    assign opnd_valid_o = beat_valid_i;

    // first beat uses the read port directly, later beats the copy
    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            src_q <= '0;
        end else if (beat_valid_i && beat_ready_o && beat_i.first) begin
            src_q <= vreg_rd_data_i;
        end
    end

    assign src = beat_i.first ? vreg_rd_data_i : src_q;

    // with boff = 4*q + r the high chunk sits q chunks below the destination chunk
    assign hi_idx = {3'b000, beat_i.chunk} - {beat_i.boff[5], beat_i.boff[5:2]};
    assign lo_idx = hi_idx - 5'd1;

    always_comb begin
        opnd_o.beat   = beat_i;
        opnd_o.hi_vld = (hi_idx[4:2] == 3'b000);  // inside 0..3
        opnd_o.lo_vld = (lo_idx[4:2] == 3'b000);
        opnd_o.hi     = src[hi_idx[1:0]*sld_pkg::OP_W +: sld_pkg::OP_W];
        opnd_o.lo     = src[lo_idx[1:0]*sld_pkg::OP_W +: sld_pkg::OP_W];
    end

endmodule

`default_nettype wire

// File: src/sld_shift.sv
// byte funnel shifter
// merges the low and high source chunks into one result chunk with byte masks

`timescale 1ns/1ps
`default_nettype none

module sld_shift (
    input  wire logic               opnd_valid_i,
    input  wire sld_pkg::sld_opnd_t opnd_i,
    output logic                    opnd_ready_o,
    output logic                    res_valid_o,
    output sld_pkg::sld_res_t       res_o,
    input  wire logic               res_ready_i
);

    localparam int unsigned NB = sld_pkg::OP_W / 8;

    logic [1:0]    rsh;      // byte offset within the chunk
    logic [NB-1:0] byte_vld;
    logic [7:0]    byte_sel [NB];

    assign opnd_ready_o = res_ready_i;
    assign res_valid_o  = opnd_valid_i;
    assign rsh          = opnd_i.beat.boff[1:0];

    always_comb begin
        for (int unsigned j = 0; j < NB; j++) begin
            if (j >= rsh) begin
                byte_sel[j] = opnd_i.hi[(j - rsh)*8 +: 8];
                byte_vld[j] = opnd_i.hi_vld;
            end else begin
                byte_sel[j] = opnd_i.lo[(j + NB - rsh)*8 +: 8];  // wraps into low chunk
                byte_vld[j] = opnd_i.lo_vld;
            end
        end
    end

    always_comb begin
        res_o.beat = opnd_i.beat;
        for (int unsigned j = 0; j < NB; j++) begin
            if (opnd_i.beat.dir == sld_pkg::SLD_DOWN) begin
                // bytes past the top of vs2 are written as zero
                res_o.data[j*8 +: 8] = byte_vld[j] ? byte_sel[j] : 8'h00;
                res_o.mask[j]        = 1'b1;
            end else begin
                res_o.data[j*8 +: 8] = byte_sel[j];
                res_o.mask[j]        = byte_vld[j];
            end
        end
    end

endmodule

`default_nettype wire

// File: src/sld_collect.sv
// result collector
// assembles four result chunks into one masked register write and reports done

`timescale 1ns/1ps
`default_nettype none

module sld_collect (
    input  wire logic                      clk_i,
    input  wire logic                      async_rst_ni,
    input  wire logic                      res_valid_i,
    input  wire sld_pkg::sld_res_t         res_i,
    output logic                           res_ready_o,
    output logic                           vreg_wr_valid_o,
    output sld_pkg::sld_wr_t               vreg_wr_o,
    input  wire logic                      vreg_wr_ready_i,
    output logic                           done_valid_o,
    output logic [sld_pkg::ID_W-1:0]       done_id_o
);

    localparam int unsigned NB = sld_pkg::OP_W / 8;

    logic                         wr_pend_q;
    logic [sld_pkg::VREG_W-1:0]   data_q;
    logic [sld_pkg::VREG_B-1:0]   mask_q;
    logic [4:0]                   addr_q;
    logic [sld_pkg::ID_W-1:0]     id_q;

    logic                         res_xfer;
    logic [NB-1:0]                tail_keep;

    assign res_ready_o = ~wr_pend_q;  // stall while a write is waiting
    assign res_xfer    = res_valid_i & res_ready_o;

    // bytes at or past vl are dropped from the mask
    always_comb begin
        for (int unsigned j = 0; j < NB; j++) begin
            tail_keep[j] = ({1'b0, res_i.beat.chunk, 2'(j)} < res_i.beat.vlb);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // chunk 0 arrives first and ends up lowest in the shift register

    always_ff @(posedge clk_i) begin
        if (res_xfer) begin
            data_q <= {res_i.data, data_q[sld_pkg::VREG_W-1:sld_pkg::OP_W]};
            mask_q <= {res_i.mask & tail_keep, mask_q[sld_pkg::VREG_B-1:NB]};
            addr_q <= res_i.beat.vd;
            id_q   <= res_i.beat.id;
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            wr_pend_q <= 1'b0;
        end else if (res_xfer && res_i.beat.last) begin
            wr_pend_q <= 1'b1;
        end else if (vreg_wr_ready_i) begin
            wr_pend_q <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // write port and done report

    assign vreg_wr_valid_o = wr_pend_q;

    always_comb begin
        vreg_wr_o.addr = addr_q;
        vreg_wr_o.data = data_q;
        vreg_wr_o.mask = mask_q;
        vreg_wr_o.id   = id_q;
    end

    assign done_valid_o = wr_pend_q & vreg_wr_ready_i;  // pulse on write transfer
    assign done_id_o    = id_q;

endmodule

`default_nettype wire

// File: src/sld_unit.sv
// vector slide unit top level
// sequencer, operand select, two pipeline stages, shifter and write collector

`timescale 1ns/1ps
`default_nettype none

module sld_unit (
    input  wire logic                        clk_i,
    input  wire logic                        async_rst_ni,
    input  wire logic                        op_valid_i,
    input  wire sld_pkg::sld_op_t            op_i,
    output logic                             op_ready_o,
    output logic [4:0]                       vreg_rd_addr_o,
    input  wire logic [sld_pkg::VREG_W-1:0]  vreg_rd_data_i,
    output logic                             vreg_wr_valid_o,
    output sld_pkg::sld_wr_t                 vreg_wr_o,
    input  wire logic                        vreg_wr_ready_i,
    output logic                             done_valid_o,
    output logic [sld_pkg::ID_W-1:0]         done_id_o
);

    logic               beat_valid, beat_ready;
    sld_pkg::sld_beat_t beat;

    logic               opnd_valid, opnd_ready;
    sld_pkg::sld_opnd_t opnd;
    logic               opnd_q_valid, opnd_q_ready;
    sld_pkg::sld_opnd_t opnd_q;

    logic               res_valid, res_ready;
    sld_pkg::sld_res_t  res;
    logic               res_q_valid, res_q_ready;
    sld_pkg::sld_res_t  res_q;

    sld_seq u_seq (
        .clk_i          (clk_i),
        .async_rst_ni   (async_rst_ni),
        .op_valid_i     (op_valid_i),
        .op_i           (op_i),
        .op_ready_o     (op_ready_o),
        .vreg_rd_addr_o (vreg_rd_addr_o),
        .beat_valid_o   (beat_valid),
        .beat_o         (beat),
        .beat_ready_i   (beat_ready)
    );

    sld_operand u_operand (
        .clk_i          (clk_i),
        .async_rst_ni   (async_rst_ni),
        .vreg_rd_data_i (vreg_rd_data_i),
        .beat_valid_i   (beat_valid),
        .beat_i         (beat),
        .beat_ready_o   (beat_ready),
        .opnd_valid_o   (opnd_valid),
        .opnd_o         (opnd),
        .opnd_ready_i   (opnd_ready)
    );

    sld_pipe_reg #(.payload_t(sld_pkg::sld_opnd_t)) u_opnd_reg (
        .clk_i (clk_i), .async_rst_ni (async_rst_ni),
        .in_valid_i  (opnd_valid),   .in_i  (opnd),   .in_ready_o  (opnd_ready),
        .out_valid_o (opnd_q_valid), .out_o (opnd_q), .out_ready_i (opnd_q_ready)
    );

    sld_shift u_shift (
        .opnd_valid_i (opnd_q_valid),
        .opnd_i       (opnd_q),
        .opnd_ready_o (opnd_q_ready),
        .res_valid_o  (res_valid),
        .res_o        (res),
        .res_ready_i  (res_ready)
    );

    sld_pipe_reg #(.payload_t(sld_pkg::sld_res_t)) u_res_reg (
        .clk_i (clk_i), .async_rst_ni (async_rst_ni),
        .in_valid_i  (res_valid),   .in_i  (res),   .in_ready_o  (res_ready),
        .out_valid_o (res_q_valid), .out_o (res_q), .out_ready_i (res_q_ready)
    );

    sld_collect u_collect (
        .clk_i           (clk_i),
        .async_rst_ni    (async_rst_ni),
        .res_valid_i     (res_q_valid),
        .res_i           (res_q),
        .res_ready_o     (res_q_ready),
        .vreg_wr_valid_o (vreg_wr_valid_o),
        .vreg_wr_o       (vreg_wr_o),
        .vreg_wr_ready_i (vreg_wr_ready_i),
        .done_valid_o    (done_valid_o),
        .done_id_o       (done_id_o)
    );

endmodule

`default_nettype wire

// File: dv/sld_unit_chk.sv
// handshake checks for the slide unit
// bound into every sld_unit instance

`timescale 1ns/1ps
`default_nettype none

module sld_unit_chk (
    input wire logic             clk_i,
    input wire logic             async_rst_ni,
    input wire logic             wr_valid_i,
    input wire sld_pkg::sld_wr_t wr_i,
    input wire logic             wr_ready_i,
    input wire logic             done_valid_i
);

    int unsigned fail_cnt = 0;  // read by the testbench

    // a stalled write keeps its address, data and mask
    wr_stable: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        wr_valid_i && !wr_ready_i |=> wr_valid_i && $stable(wr_i))
        else begin
            $error("register write changed while stalled");
            fail_cnt++;
        end

    done_with_wr: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        done_valid_i |-> wr_valid_i && wr_ready_i)
        else begin
            $error("done report without a write transfer");
            fail_cnt++;
        end

    quiet_in_reset: assert property (@(posedge clk_i)
        !async_rst_ni |-> !wr_valid_i && !done_valid_i)
        else begin
            $error("valid output high during reset");
            fail_cnt++;
        end

endmodule

bind sld_unit sld_unit_chk u_chk (
    .clk_i        (clk_i),
    .async_rst_ni (async_rst_ni),
    .wr_valid_i   (vreg_wr_valid_o),
    .wr_i         (vreg_wr_o),
    .wr_ready_i   (vreg_wr_ready_i),
    .done_valid_i (done_valid_o)
);

`default_nettype wire

// File: dv/tb_sld_unit.sv
// testbench for the vector slide unit
// register file model, table of slide operations, in-order write and done checks

`timescale 1ns/1ps
`default_nettype none

module tb_sld_unit;

    localparam int NROWS = 14;
    localparam int NPASS = 2;                       // full ready, then random ready
    localparam int LIMIT = 40 * NROWS * NPASS + 100;  // timeout in cycles

    typedef struct packed {
        sld_pkg::dir_e              dir;
        sld_pkg::eew_e              eew;
        logic [3:0]                 off;
        logic [4:0]                 vl;
        logic [4:0]                 vs2;
        logic [4:0]                 vd;
        logic [sld_pkg::VREG_B-1:0] mask;  // expected byte mask
    } row_t;

    logic                       clk_i = 1'b0;
    logic                       async_rst_ni;
    logic                       op_valid_i;
    sld_pkg::sld_op_t           op_i;
    logic                       op_ready_o;
    logic [4:0]                 vreg_rd_addr_o;
    logic [sld_pkg::VREG_W-1:0] vreg_rd_data_i;
    logic                       vreg_wr_valid_o;
    sld_pkg::sld_wr_t           vreg_wr_o;
    logic                       vreg_wr_ready_i;
    logic                       done_valid_o;
    logic [sld_pkg::ID_W-1:0]   done_id_o;

    row_t                       rows [NROWS];
    logic [sld_pkg::VREG_W-1:0] rf [32];    // writes are checked, never stored
    logic [4:0]                 rd_addr_q;
    logic [31:0]                lfsr_q = 32'he6e5a35c;
    logic                       rand_ready;
    int                         n_writes = 0;
    int                         cycles = 0;
    sld_pkg::sld_wr_t           exp_q [$];  // expected writes in issue order
    sld_pkg::sld_wr_t           exp_wr;

    always #5 clk_i = ~clk_i;

    sld_unit DUT (
        .clk_i           (clk_i),
        .async_rst_ni    (async_rst_ni),
        .op_valid_i      (op_valid_i),
        .op_i            (op_i),
        .op_ready_o      (op_ready_o),
        .vreg_rd_addr_o  (vreg_rd_addr_o),
        .vreg_rd_data_i  (vreg_rd_data_i),
        .vreg_wr_valid_o (vreg_wr_valid_o),
        .vreg_wr_o       (vreg_wr_o),
        .vreg_wr_ready_i (vreg_wr_ready_i),
        .done_valid_o    (done_valid_o),
        .done_id_o       (done_id_o)
    );

    ////////////////////////////////////////////////////////////////////////////
    // helpers

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [127:0] got,
                                   input logic [127:0] want);
        abort_run($sformatf("CHECK FAILED at %0t: %s is %0h, expected %0h",
                            $time, name, got, want));
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        // galois form of x^32 + x^22 + x^2 + x + 1
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end else begin
            return s >> 1;
        end
    endfunction

    task automatic take_bit(output logic b);
        b      = lfsr_q[0];
        lfsr_q = lfsr_next(lfsr_q);
    endtask

    task automatic fill_regfile();
        logic [sld_pkg::VREG_W-1:0] word;
        logic                       b;
        for (int r = 0; r < 32; r++) begin
            for (int k = 0; k < sld_pkg::VREG_W; k++) begin
                take_bit(b);
                word = {b, word[sld_pkg::VREG_W-1:1]};
            end
            rf[r] = word;
        end
    endtask

    // expected write data from the slide rules
    function automatic logic [127:0] slide_ref(input logic [127:0] src,
                                               input sld_pkg::dir_e dir,
                                               input sld_pkg::eew_e eew,
                                               input logic [3:0] off);
        logic [127:0] res;
        int           sz;
        int           sh;
        case (eew)
            sld_pkg::EEW_16: sz = 2;
            sld_pkg::EEW_32: sz = 4;
            default:         sz = 1;
        endcase
        sh  = int'(off) * sz;
        res = '0;                               // zero fill past the top
        for (int i = 0; i < 16; i++) begin
            if (dir == sld_pkg::SLD_UP && i >= sh) begin
                res[i*8 +: 8] = src[(i - sh)*8 +: 8];
            end else if (dir == sld_pkg::SLD_DOWN && i + sh < 16) begin
                res[i*8 +: 8] = src[(i + sh)*8 +: 8];
            end
        end
        return res;
    endfunction

    task automatic load_table();
        // dir, eew, offset, vl, vs2, vd, expected mask
        rows[0]  = '{sld_pkg::SLD_UP,   sld_pkg::EEW_8,  4'd3,  5'd16, 5'd1,  5'd17, 16'hFFF8};
        rows[1]  = '{sld_pkg::SLD_UP,   sld_pkg::EEW_16, 4'd2,  5'd8,  5'd2,  5'd18, 16'hFFF0};
        rows[2]  = '{sld_pkg::SLD_UP,   sld_pkg::EEW_32, 4'd3,  5'd16, 5'd3,  5'd19, 16'hF000};
        rows[3]  = '{sld_pkg::SLD_UP,   sld_pkg::EEW_8,  4'd0,  5'd16, 5'd4,  5'd20, 16'hFFFF};
        rows[4]  = '{sld_pkg::SLD_UP,   sld_pkg::EEW_32, 4'd4,  5'd4,  5'd5,  5'd21, 16'h0000};
        rows[5]  = '{sld_pkg::SLD_DOWN, sld_pkg::EEW_8,  4'd5,  5'd16, 5'd6,  5'd22, 16'hFFFF};
        rows[6]  = '{sld_pkg::SLD_DOWN, sld_pkg::EEW_16, 4'd3,  5'd8,  5'd7,  5'd23, 16'hFFFF};
        rows[7]  = '{sld_pkg::SLD_DOWN, sld_pkg::EEW_32, 4'd4,  5'd4,  5'd8,  5'd24, 16'hFFFF};
        rows[8]  = '{sld_pkg::SLD_DOWN, sld_pkg::EEW_32, 4'd15, 5'd4,  5'd9,  5'd25, 16'hFFFF};
        rows[9]  = '{sld_pkg::SLD_UP,   sld_pkg::EEW_8,  4'd2,  5'd7,  5'd10, 5'd26, 16'h007C};
        rows[10] = '{sld_pkg::SLD_DOWN, sld_pkg::EEW_16, 4'd1,  5'd3,  5'd11, 5'd27, 16'h003F};
        rows[11] = '{sld_pkg::SLD_UP,   sld_pkg::EEW_16, 4'd0,  5'd0,  5'd12, 5'd28, 16'h0000};
        rows[12] = '{sld_pkg::SLD_DOWN, sld_pkg::EEW_8,  4'd7,  5'd0,  5'd13, 5'd29, 16'h0000};
        rows[13] = '{sld_pkg::SLD_DOWN, sld_pkg::EEW_8,  4'd12, 5'd14, 5'd14, 5'd30, 16'h3FFF};
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // compare tasks

    task automatic expect_flag(input string name, input logic got, input logic want);
        if (got !== want) report_mismatch(name, 128'(got), 128'(want));
    endtask

    task automatic verify_done_id(input logic [sld_pkg::ID_W-1:0] got,
                                  input logic [sld_pkg::ID_W-1:0] want);
        if (got !== want) report_mismatch("done_id_o", 128'(got), 128'(want));
    endtask

    task automatic compare_write(input sld_pkg::sld_wr_t got, input sld_pkg::sld_wr_t want);
        if (got.addr !== want.addr) begin
            report_mismatch("vreg_wr_o.addr", 128'(got.addr), 128'(want.addr));
        end
        if (got.id !== want.id) report_mismatch("vreg_wr_o.id", 128'(got.id), 128'(want.id));
        if (got.mask !== want.mask) begin
            report_mismatch("vreg_wr_o.mask", 128'(got.mask), 128'(want.mask));
        end
        for (int b = 0; b < sld_pkg::VREG_B; b++) begin
            if (want.mask[b] && got.data[b*8 +: 8] !== want.data[b*8 +: 8]) begin
                report_mismatch("vreg_wr_o.data", got.data, want.data);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // register file model driven on the falling edge

    always @(negedge clk_i) begin
        if (DUT.u_chk.fail_cnt != 0) begin
            abort_run("a handshake assertion failed in the bound checker");
        end else begin
            vreg_rd_data_i = rf[rd_addr_q];  // one cycle behind the address
            rd_addr_q      = vreg_rd_addr_o;
            if (rand_ready) begin
                take_bit(vreg_wr_ready_i);
            end else begin
                vreg_wr_ready_i = 1'b1;
            end
        end
    end

    // writes and done reports are checked at the rising edge of the transfer
    always @(posedge clk_i) begin
        if (async_rst_ni) begin
            if (vreg_wr_valid_o && vreg_wr_ready_i) begin
                if (exp_q.size() == 0) begin
                    abort_run("register write seen with no operation outstanding");
                end else begin
                    exp_wr = exp_q.pop_front();
                    compare_write(vreg_wr_o, exp_wr);
                    expect_flag("done_valid_o", done_valid_o, 1'b1);
                    verify_done_id(done_id_o, exp_wr.id);
                    n_writes = n_writes + 1;
                end
            end else begin
                expect_flag("done_valid_o", done_valid_o, 1'b0);
            end
        end
    end

    always @(posedge clk_i) begin
        cycles = cycles + 1;
        if (cycles >= LIMIT) begin
            abort_run($sformatf("timeout after %0d cycles, %0d of %0d writes seen",
                                cycles, n_writes, NROWS * NPASS));
        end
    end

    // holds the op until accepted and queues its expected write
    task automatic issue_op(input int r, input int seq);
        sld_pkg::sld_op_t op;
        sld_pkg::sld_wr_t want;
        op.id      = seq[sld_pkg::ID_W-1:0];
        op.dir     = rows[r].dir;
        op.eew     = rows[r].eew;
        op.offset  = rows[r].off;
        op.vl      = rows[r].vl;
        op.vs2     = rows[r].vs2;
        op.vd      = rows[r].vd;
        want.addr  = rows[r].vd;
        want.data  = slide_ref(rf[rows[r].vs2], rows[r].dir, rows[r].eew, rows[r].off);
        want.mask  = rows[r].mask;
        want.id    = op.id;
        op_i       = op;
        op_valid_i = 1'b1;
        while (!op_ready_o) @(negedge clk_i);
        exp_q.push_back(want);           // taken at the next rising edge
        @(negedge clk_i);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence

    initial begin
        int seq;
        async_rst_ni    = 1'b0;
        op_valid_i      = 1'b0;
        op_i            = '0;
        vreg_rd_data_i  = '0;
        vreg_wr_ready_i = 1'b1;
        rd_addr_q       = '0;
        rand_ready      = 1'b0;
        seq             = 0;
        load_table();
        fill_regfile();
        repeat (5) @(negedge clk_i);
        async_rst_ni = 1'b1;
        @(negedge clk_i);
        expect_flag("op_ready_o", op_ready_o, 1'b1);
        expect_flag("vreg_wr_valid_o", vreg_wr_valid_o, 1'b0);
        expect_flag("done_valid_o", done_valid_o, 1'b0);

        for (int p = 0; p < NPASS; p++) begin
            rand_ready = (p == 1);  // second pass stalls the write port
            for (int r = 0; r < NROWS; r++) begin
                issue_op(r, seq);
                seq = seq + 1;
            end
            op_valid_i = 1'b0;
            while (n_writes < seq) @(negedge clk_i);
        end

        if (exp_q.size() == 0 && n_writes == NROWS * NPASS) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            abort_run("write count does not match the issued operations");
        end
    end

endmodule

`default_nettype wire

// File: project.f
src/sld_pkg.sv
src/sld_pipe_reg.sv
src/sld_seq.sv
src/sld_operand.sv
src/sld_shift.sv
src/sld_collect.sv
src/sld_unit.sv
dv/sld_unit_chk.sv
dv/tb_sld_unit.sv

// File: run_sim.sh
#!/bin/sh
# build the slide unit testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -j 0 \
    --top-module tb_sld_unit -Mdir obj_dir -o Vtb_sld_unit -f project.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_sld_unit > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "SIMULATION PASSED" "$LOG"; then
    echo "run ok"
    exit 0
else
    echo "run not ok, see $LOG"
    exit 1
fi
